//--- logic/ooo_cfg_pkg.sv
`default_nettype none

package ooo_cfg_pkg;

    typedef logic [31:0] data_t;        // operand and result value.
    typedef logic [3:0]  reg_addr_t;    // 16 architectural registers.

    localparam int ROB_DEPTH = 8;

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

    typedef logic [2:0] op_t;

    localparam op_t OP_ADD = 3'd0;
    localparam op_t OP_SUB = 3'd1;
    localparam op_t OP_AND = 3'd2;
    localparam op_t OP_OR  = 3'd3;
    localparam op_t OP_XOR = 3'd4;
    localparam op_t OP_LI  = 3'd5;     // rd gets imm.
    localparam op_t OP_MUL = 3'd6;     // only op sent to the multiply station.

endpackage

`default_nettype wire

//--- logic/ooo_types_pkg.sv
`default_nettype none

package ooo_types_pkg;

    typedef struct packed {
        ooo_cfg_pkg::op_t       op;
        ooo_cfg_pkg::reg_addr_t rd;
        ooo_cfg_pkg::reg_addr_t rs1;
        ooo_cfg_pkg::reg_addr_t rs2;
        ooo_cfg_pkg::data_t     imm;
    } instr_t;

    // tag is only meaningful while ready is low.
    typedef struct packed {
        logic                  ready;
        ooo_cfg_pkg::rob_tag_t tag;
        ooo_cfg_pkg::data_t    value;
    } operand_t;

    typedef struct packed {
        ooo_cfg_pkg::op_t      op;
        ooo_cfg_pkg::rob_tag_t tag;
        operand_t              src1;
        operand_t              src2;
        ooo_cfg_pkg::data_t    imm;
    } dispatch_t;

    typedef struct packed {
        logic                  valid;
        ooo_cfg_pkg::rob_tag_t tag;
        ooo_cfg_pkg::data_t    value;
    } cdb_t;

    typedef struct packed {
        ooo_cfg_pkg::reg_addr_t rd;
        ooo_cfg_pkg::rob_tag_t  tag;
        ooo_cfg_pkg::data_t     value;
    } commit_t;

endpackage

`default_nettype wire

//--- logic/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     alloc_en,
    input  wire ooo_cfg_pkg::reg_addr_t   alloc_rd,
    output ooo_cfg_pkg::rob_tag_t         alloc_tag,
    output logic                          rob_full,
    input  wire ooo_cfg_pkg::rob_tag_t    look_tag1,
    input  wire ooo_cfg_pkg::rob_tag_t    look_tag2,
    output ooo_types_pkg::operand_t       look1,
    output ooo_types_pkg::operand_t       look2,
    input  wire ooo_types_pkg::cdb_t      alu_cdb,
    input  wire ooo_types_pkg::cdb_t      mul_cdb,
    output logic                          commit_valid,
    output ooo_types_pkg::commit_t        commit
);

    localparam int CNT_W = $clog2(ooo_cfg_pkg::ROB_DEPTH) + 1;

    ooo_cfg_pkg::reg_addr_t            dest_q  [ooo_cfg_pkg::ROB_DEPTH];
    ooo_cfg_pkg::data_t                value_q [ooo_cfg_pkg::ROB_DEPTH];
    logic [ooo_cfg_pkg::ROB_DEPTH-1:0] valid_q;    // result written, not yet retired.
    ooo_cfg_pkg::rob_tag_t             alloc_ptr;
    ooo_cfg_pkg::rob_tag_t             head_ptr;
    logic [CNT_W-1:0]                  count;

    // a result arriving this cycle is as good as one already stored.
    function automatic ooo_types_pkg::operand_t lookup(input ooo_cfg_pkg::rob_tag_t tag);
        ooo_types_pkg::operand_t res;
        res.tag   = tag;
        res.ready = valid_q[tag];
        res.value = value_q[tag];
        if (alu_cdb.valid && alu_cdb.tag == tag) begin
            res.ready = 1'b1;
            res.value = alu_cdb.value;
        end else if (mul_cdb.valid && mul_cdb.tag == tag) begin
            res.ready = 1'b1;
            res.value = mul_cdb.value;
        end
        return res;
    endfunction

    always_comb begin
        look1 = lookup(look_tag1);
        look2 = lookup(look_tag2);
    end

    assign alloc_tag    = alloc_ptr;
    assign rob_full     = (count == CNT_W'(ooo_cfg_pkg::ROB_DEPTH));
    assign commit_valid = valid_q[head_ptr];    // head retires as soon as it has a result.
    assign commit       = '{rd: dest_q[head_ptr], tag: head_ptr, value: value_q[head_ptr]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q   <= '0;
            alloc_ptr <= '0;
            head_ptr  <= '0;
            count     <= '0;
        end else begin
            if (alu_cdb.valid) begin
                valid_q[alu_cdb.tag] <= 1'b1;
            end
            if (mul_cdb.valid) begin
                valid_q[mul_cdb.tag] <= 1'b1;
            end
            if (alloc_en) begin
                valid_q[alloc_ptr] <= 1'b0;
                alloc_ptr          <= alloc_ptr + 1'b1;
            end
            if (commit_valid) begin
                valid_q[head_ptr] <= 1'b0;
                head_ptr          <= head_ptr + 1'b1;
            end
            if (alloc_en && !commit_valid) begin
                count <= count + 1'b1;
            end else if (!alloc_en && commit_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_cdb.valid) begin
            value_q[alu_cdb.tag] <= alu_cdb.value;
        end
        if (mul_cdb.valid) begin
            value_q[mul_cdb.tag] <= mul_cdb.value;
        end
        if (alloc_en) begin
            dest_q[alloc_ptr] <= alloc_rd;
        end
    end

    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        alloc_en |-> !rob_full);

    // distance from head must fall inside the occupied window.
    a_alu_cdb_allocated: assert property (@(posedge clk) disable iff (rst)
        alu_cdb.valid |-> ooo_cfg_pkg::rob_tag_t'(alu_cdb.tag - head_ptr) < count);
    a_mul_cdb_allocated: assert property (@(posedge clk) disable iff (rst)
        mul_cdb.valid |-> ooo_cfg_pkg::rob_tag_t'(mul_cdb.tag - head_ptr) < count);

endmodule

`default_nettype wire

//--- logic/arch_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module arch_regfile (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire ooo_cfg_pkg::reg_addr_t   rs1,
    input  wire ooo_cfg_pkg::reg_addr_t   rs2,
    output ooo_types_pkg::operand_t       src1,
    output ooo_types_pkg::operand_t       src2,
    input  wire logic                     rename_en,
    input  wire ooo_cfg_pkg::reg_addr_t   rename_rd,
    input  wire ooo_cfg_pkg::rob_tag_t    rename_tag,
    input  wire logic                     commit_valid,
    input  wire ooo_types_pkg::commit_t   commit
);

    localparam int NUM_REGS = 2 ** $bits(ooo_cfg_pkg::reg_addr_t);

    ooo_cfg_pkg::data_t    value_q [NUM_REGS];
    ooo_cfg_pkg::rob_tag_t tag_q   [NUM_REGS];     // youngest producer.
    logic [NUM_REGS-1:0]   busy_q;

    function automatic ooo_types_pkg::operand_t read_reg(input ooo_cfg_pkg::reg_addr_t ra);
        ooo_types_pkg::operand_t res;
        res.ready = !busy_q[ra];
        res.tag   = tag_q[ra];
        res.value = busy_q[ra] ? '0 : value_q[ra];
        return res;
    endfunction

    always_comb begin
        src1 = read_reg(rs1);
        src2 = read_reg(rs2);
    end

    // x0 is never written nor renamed, so it stays zero and idle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (commit_valid && commit.rd != '0) begin
                value_q[commit.rd] <= commit.value;
                if (busy_q[commit.rd] && tag_q[commit.rd] == commit.tag) begin
                    busy_q[commit.rd] <= 1'b0;   // only the youngest producer frees it.
                end
            end
            if (rename_en && rename_rd != '0) begin
                busy_q[rename_rd] <= 1'b1;      // later write wins over commit.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_en && rename_rd != '0) begin
            tag_q[rename_rd] <= rename_tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/dispatch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_unit (
    input  wire logic                     instr_valid,
    output logic                          instr_ready,
    input  wire ooo_types_pkg::instr_t    instr,
    output ooo_cfg_pkg::reg_addr_t        rf_rs1,
    output ooo_cfg_pkg::reg_addr_t        rf_rs2,
    input  wire ooo_types_pkg::operand_t  rf_src1,
    input  wire ooo_types_pkg::operand_t  rf_src2,
    output logic                          rename_en,
    output ooo_cfg_pkg::reg_addr_t        rename_rd,
    output ooo_cfg_pkg::rob_tag_t         rename_tag,
    output logic                          alloc_en,
    output ooo_cfg_pkg::reg_addr_t        alloc_rd,
    input  wire ooo_cfg_pkg::rob_tag_t    alloc_tag,
    input  wire logic                     rob_full,
    output ooo_cfg_pkg::rob_tag_t         look_tag1,
    output ooo_cfg_pkg::rob_tag_t         look_tag2,
    input  wire ooo_types_pkg::operand_t  look1,
    input  wire ooo_types_pkg::operand_t  look2,
    output logic                          alu_disp_valid,
    output logic                          mul_disp_valid,
    output ooo_types_pkg::dispatch_t      disp,
    input  wire logic                     alu_rs_full,
    input  wire logic                     mul_rs_full
);

    logic is_mul;
    logic is_li;
    logic accept;

    // regfile value if idle, otherwise whatever the ROB knows about the tag.
    function automatic ooo_types_pkg::operand_t resolve(input ooo_types_pkg::operand_t rf,
                                                        input ooo_types_pkg::operand_t rob,
                                                        input logic force_ready);
        ooo_types_pkg::operand_t res;
        res = rf.ready ? rf : rob;
        if (force_ready) begin
            res.ready = 1'b1;
        end
        return res;
    endfunction

    assign is_mul      = (instr.op == ooo_cfg_pkg::OP_MUL);
    assign is_li       = (instr.op == ooo_cfg_pkg::OP_LI);
    assign instr_ready = !rob_full && !(is_mul ? mul_rs_full : alu_rs_full);
    assign accept      = instr_valid && instr_ready;

    assign rf_rs1    = instr.rs1;
    assign rf_rs2    = instr.rs2;
    assign look_tag1 = rf_src1.tag;
    assign look_tag2 = rf_src2.tag;

    assign alloc_en   = accept;
    assign alloc_rd   = instr.rd;
    assign rename_en  = accept;
    assign rename_rd  = instr.rd;
    assign rename_tag = alloc_tag;

    assign alu_disp_valid = accept && !is_mul;
    assign mul_disp_valid = accept && is_mul;

    always_comb begin
        disp.op   = instr.op;
        disp.tag  = alloc_tag;
        disp.src1 = resolve(rf_src1, look1, is_li);   // li reads no register.
        disp.src2 = resolve(rf_src2, look2, is_li);
        disp.imm  = instr.imm;
    end

endmodule

`default_nettype wire

//--- logic/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       disp_valid,
    input  wire ooo_types_pkg::dispatch_t   disp,
    output logic                            full,
    input  wire ooo_types_pkg::cdb_t        alu_cdb,
    input  wire ooo_types_pkg::cdb_t        mul_cdb,
    output logic                            issue_valid,
    output ooo_types_pkg::dispatch_t        issue
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    ooo_types_pkg::dispatch_t entry_q [RS_DEPTH];
    logic [RS_DEPTH-1:0]      valid_q;
    logic [IDX_W-1:0]         free_idx;
    logic [IDX_W-1:0]         issue_idx;

    function automatic ooo_types_pkg::operand_t capture(input ooo_types_pkg::operand_t opnd,
                                                        input ooo_types_pkg::cdb_t a,
                                                        input ooo_types_pkg::cdb_t b);
        ooo_types_pkg::operand_t res;
        res = opnd;
        if (!opnd.ready && a.valid && a.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = a.value;
        end else if (!opnd.ready && b.valid && b.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = b.value;
        end
        return res;
    endfunction

    // scan downward so the lowest index wins.
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
            if (valid_q[i] && entry_q[i].src1.ready && entry_q[i].src2.ready) begin
                issue_valid = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    assign full  = &valid_q;
    assign issue = entry_q[issue_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            if (issue_valid) begin
                valid_q[issue_idx] <= 1'b0;
            end
            if (disp_valid) begin
                valid_q[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (disp_valid && free_idx == IDX_W'(i)) begin
                entry_q[i] <= disp;   // same-cycle results were bypassed at dispatch.
            end else begin
                entry_q[i].src1 <= capture(entry_q[i].src1, alu_cdb, mul_cdb);
                entry_q[i].src2 <= capture(entry_q[i].src2, alu_cdb, mul_cdb);
            end
        end
    end

    a_no_disp_when_full: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> !full);

endmodule

`default_nettype wire

//--- logic/exec_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module exec_pipe #(
    parameter int LATENCY = 1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       issue_valid,
    input  wire ooo_types_pkg::dispatch_t   issue,
    output ooo_types_pkg::cdb_t             cdb
);

    logic [LATENCY-1:0]    valid_q;
    ooo_cfg_pkg::rob_tag_t tag_q   [LATENCY];
    ooo_cfg_pkg::data_t    value_q [LATENCY];
    ooo_cfg_pkg::data_t    result;

    always_comb begin
        case (issue.op)
            ooo_cfg_pkg::OP_ADD: result = issue.src1.value + issue.src2.value;
            ooo_cfg_pkg::OP_SUB: result = issue.src1.value - issue.src2.value;
            ooo_cfg_pkg::OP_AND: result = issue.src1.value & issue.src2.value;
            ooo_cfg_pkg::OP_OR:  result = issue.src1.value | issue.src2.value;
            ooo_cfg_pkg::OP_XOR: result = issue.src1.value ^ issue.src2.value;
            ooo_cfg_pkg::OP_LI:  result = issue.imm;
            ooo_cfg_pkg::OP_MUL: result = issue.src1.value * issue.src2.value; // low half.
            default:             result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue_valid;
            for (int i = 1; i < LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // shift register, one result per stage.
    always_ff @(posedge clk) begin
        tag_q[0]   <= issue.tag;
        value_q[0] <= result;
        for (int i = 1; i < LATENCY; i++) begin
            tag_q[i]   <= tag_q[i-1];
            value_q[i] <= value_q[i-1];
        end
    end

    assign cdb = '{valid: valid_q[LATENCY-1], tag: tag_q[LATENCY-1], value: value_q[LATENCY-1]};

endmodule

`default_nettype wire

//--- logic/ooo_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module ooo_core_top #(
    parameter int RS_DEPTH    = 4,
    parameter int ALU_LATENCY = 1,
    parameter int MUL_LATENCY = 3
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     instr_valid,
    output logic                          instr_ready,
    input  wire ooo_types_pkg::instr_t    instr,
    output logic                          commit_valid,
    output ooo_types_pkg::commit_t        commit
);

    ooo_cfg_pkg::reg_addr_t    rf_rs1, rf_rs2, rename_rd, alloc_rd;
    ooo_cfg_pkg::rob_tag_t     rename_tag, alloc_tag, look_tag1, look_tag2;
    ooo_types_pkg::operand_t   rf_src1, rf_src2, look1, look2;
    ooo_types_pkg::dispatch_t  disp, alu_issue, mul_issue;
    ooo_types_pkg::cdb_t       alu_cdb, mul_cdb;
    logic                      rename_en, alloc_en, rob_full;
    logic                      alu_disp_valid, mul_disp_valid, alu_rs_full, mul_rs_full;
    logic                      alu_issue_valid, mul_issue_valid;

    dispatch_unit u_dispatch (
        .instr_valid, .instr_ready, .instr,
        .rf_rs1, .rf_rs2, .rf_src1, .rf_src2,
        .rename_en, .rename_rd, .rename_tag,
        .alloc_en, .alloc_rd, .alloc_tag, .rob_full,
        .look_tag1, .look_tag2, .look1, .look2,
        .alu_disp_valid, .mul_disp_valid, .disp,
        .alu_rs_full, .mul_rs_full
    );

    arch_regfile u_regfile (
        .clk, .rst, .rs1(rf_rs1), .rs2(rf_rs2), .src1(rf_src1), .src2(rf_src2),
        .rename_en, .rename_rd, .rename_tag, .commit_valid, .commit
    );

    reorder_buffer u_rob (
        .clk, .rst, .alloc_en, .alloc_rd, .alloc_tag, .rob_full,
        .look_tag1, .look_tag2, .look1, .look2,
        .alu_cdb, .mul_cdb, .commit_valid, .commit
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_alu_rs (
        .clk, .rst, .disp_valid(alu_disp_valid), .disp, .full(alu_rs_full),
        .alu_cdb, .mul_cdb, .issue_valid(alu_issue_valid), .issue(alu_issue)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_mul_rs (
        .clk, .rst, .disp_valid(mul_disp_valid), .disp, .full(mul_rs_full),
        .alu_cdb, .mul_cdb, .issue_valid(mul_issue_valid), .issue(mul_issue)
    );

    exec_pipe #(.LATENCY(ALU_LATENCY)) u_alu_pipe (
        .clk, .rst, .issue_valid(alu_issue_valid), .issue(alu_issue), .cdb(alu_cdb)
    );

    exec_pipe #(.LATENCY(MUL_LATENCY)) u_mul_pipe (
        .clk, .rst, .issue_valid(mul_issue_valid), .issue(mul_issue), .cdb(mul_cdb)
    );

endmodule

`default_nettype wire

//--- dv/clk_rst_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_rst_gen #(
    parameter real PERIOD_NS  = 10.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;    // released on the second rising edge.
    end

endmodule

`default_nettype wire

//--- dv/ooo_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ooo_core_tb;

    localparam int NUM_TESTS      = 6;
    localparam int RESET_TIMEOUT  = 20;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 500;
    localparam int IDLE_CYCLES    = 8;

    typedef struct packed {
        logic [3:0]            test;
        ooo_types_pkg::instr_t ins;
    } row_t;

    typedef struct packed {
        logic [3:0]             test;
        ooo_cfg_pkg::reg_addr_t rd;
        ooo_cfg_pkg::rob_tag_t  tag;
        ooo_cfg_pkg::data_t     value;
    } expect_t;

    logic                    clk;
    logic                    rst;
    logic                    instr_valid = 1'b0;
    logic                    instr_ready;
    ooo_types_pkg::instr_t   instr = '0;
    logic                    commit_valid;
    ooo_types_pkg::commit_t  commit;

    row_t    prog [$];
    expect_t exp_q [$];
    int      seed = 32'h7ac6_1259;
    int      test_rows    [NUM_TESTS+1];
    int      test_commits [NUM_TESTS+1];
    int      test_errors  [NUM_TESTS+1];
    int      stall_cycles [NUM_TESTS+1];
    int      commits;
    int      other_fails;

    clk_rst_gen u_clk_rst (.clk, .rst);

    ooo_core_top #(.RS_DEPTH(4), .ALU_LATENCY(1), .MUL_LATENCY(3)) u_dut (
        .clk, .rst, .instr_valid, .instr_ready, .instr, .commit_valid, .commit
    );

    task automatic add_row(input int test, input ooo_cfg_pkg::op_t op,
                           input ooo_cfg_pkg::reg_addr_t rd, input ooo_cfg_pkg::reg_addr_t rs1,
                           input ooo_cfg_pkg::reg_addr_t rs2, input ooo_cfg_pkg::data_t imm);
        row_t r;
        r.test = test[3:0];
        r.ins  = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
        prog.push_back(r);
    endtask

    task automatic load_program();
        add_row(1, ooo_cfg_pkg::OP_LI,  4'd1,  4'd0,  4'd0, 32'd5);
        add_row(1, ooo_cfg_pkg::OP_LI,  4'd2,  4'd0,  4'd0, 32'd7);
        add_row(1, ooo_cfg_pkg::OP_LI,  4'd3,  4'd0,  4'd0, 32'hf0f0_1234);
        add_row(1, ooo_cfg_pkg::OP_SUB, 4'd4,  4'd1,  4'd2, 32'd0);   // wraps below zero.
        add_row(1, ooo_cfg_pkg::OP_AND, 4'd5,  4'd3,  4'd2, 32'd0);
        add_row(1, ooo_cfg_pkg::OP_XOR, 4'd6,  4'd3,  4'd1, 32'd0);
        add_row(2, ooo_cfg_pkg::OP_ADD, 4'd7,  4'd1,  4'd2, 32'd0);
        add_row(2, ooo_cfg_pkg::OP_ADD, 4'd7,  4'd7,  4'd1, 32'd0);
        add_row(2, ooo_cfg_pkg::OP_SUB, 4'd8,  4'd7,  4'd2, 32'd0);
        add_row(2, ooo_cfg_pkg::OP_OR,  4'd8,  4'd8,  4'd7, 32'd0);
        add_row(3, ooo_cfg_pkg::OP_MUL, 4'd9,  4'd3,  4'd2, 32'd0);
        add_row(3, ooo_cfg_pkg::OP_ADD, 4'd10, 4'd1,  4'd2, 32'd0);
        add_row(3, ooo_cfg_pkg::OP_XOR, 4'd11, 4'd3,  4'd1, 32'd0);
        add_row(3, ooo_cfg_pkg::OP_ADD, 4'd12, 4'd9,  4'd1, 32'd0);
        add_row(4, ooo_cfg_pkg::OP_MUL, 4'd13, 4'd2,  4'd2, 32'd0);
        for (int i = 0; i < 7; i++) begin
            add_row(4, ooo_cfg_pkg::OP_MUL, 4'd13, 4'd13, 4'd2, 32'd0);   // serial chain.
        end
        add_row(5, ooo_cfg_pkg::OP_LI,  4'd0,  4'd0,  4'd0, 32'd99);
        add_row(5, ooo_cfg_pkg::OP_ADD, 4'd0,  4'd1,  4'd2, 32'd0);
        add_row(5, ooo_cfg_pkg::OP_ADD, 4'd14, 4'd0,  4'd1, 32'd0);
        add_row(5, ooo_cfg_pkg::OP_MUL, 4'd15, 4'd0,  4'd2, 32'd0);
        add_row(6, ooo_cfg_pkg::OP_MUL, 4'd9,  4'd2,  4'd2, 32'd0);
        add_row(6, ooo_cfg_pkg::OP_ADD, 4'd9,  4'd9,  4'd1, 32'd0);
        add_row(6, ooo_cfg_pkg::OP_LI,  4'd9,  4'd0,  4'd0, 32'd100);
        add_row(6, ooo_cfg_pkg::OP_ADD, 4'd10, 4'd9,  4'd1, 32'd0);
        add_row(6, ooo_cfg_pkg::OP_ADD, 4'd10, 4'd10, 4'd9, 32'd0);
    endtask

    function automatic ooo_cfg_pkg::data_t model_op(input ooo_cfg_pkg::op_t op,
                                                    input ooo_cfg_pkg::data_t a,
                                                    input ooo_cfg_pkg::data_t b,
                                                    input ooo_cfg_pkg::data_t imm);
        case (op)
            ooo_cfg_pkg::OP_ADD: return a + b;
            ooo_cfg_pkg::OP_SUB: return a - b;
            ooo_cfg_pkg::OP_AND: return a & b;
            ooo_cfg_pkg::OP_OR:  return a | b;
            ooo_cfg_pkg::OP_XOR: return a ^ b;
            ooo_cfg_pkg::OP_LI:  return imm;
            ooo_cfg_pkg::OP_MUL: return a * b;
            default:             return '0;
        endcase
    endfunction

    // sequential reference, one instruction at a time in program order.
    task automatic build_expected();
        ooo_cfg_pkg::data_t regs [16];
        ooo_cfg_pkg::data_t res;
        expect_t            e;
        foreach (regs[i]) regs[i] = '0;
        foreach (prog[i]) begin
            res = model_op(prog[i].ins.op, regs[prog[i].ins.rs1], regs[prog[i].ins.rs2],
                           prog[i].ins.imm);
            e.test  = prog[i].test;
            e.rd    = prog[i].ins.rd;
            // tags are handed out in program order and wrap around the ROB.
            e.tag   = ooo_cfg_pkg::rob_tag_t'(i % ooo_cfg_pkg::ROB_DEPTH);
            e.value = res;
            exp_q.push_back(e);
            if (prog[i].ins.rd != 4'd0) begin
                regs[prog[i].ins.rd] = res;
            end
            test_rows[prog[i].test]++;
        end
    endtask

    task automatic wait_reset(output bit ok);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (rst && waited < RESET_TIMEOUT);
        ok = !rst;
        if (!ok) $display("reset was still asserted after %0d cycles", waited);
    endtask

    task automatic drive_program(output bit ok);
        int gap;
        int waited;
        ok = 1'b1;
        foreach (prog[i]) begin
            gap = $random(seed) & 7;
            if (gap > 5) begin
                instr_valid <= 1'b0;
                repeat (gap - 5) @(posedge clk);
            end
            instr_valid <= 1'b1;
            instr       <= prog[i].ins;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (!instr_ready) stall_cycles[prog[i].test]++;
            end while (!instr_ready && waited < ACCEPT_TIMEOUT);
            if (!instr_ready) begin
                $display("instruction %0d was not accepted within %0d cycles", i, waited);
                ok = 1'b0;
                return;
            end
        end
        instr_valid <= 1'b0;
    endtask

    task automatic wait_drain(output bit ok);
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        ok = (exp_q.size() == 0);
        if (!ok) $display("%0d commits still missing after %0d cycles", exp_q.size(), waited);
    endtask

    always @(posedge clk) begin : check_commit
        expect_t want;
        if (!rst && commit_valid) begin
            commits++;
            assert (exp_q.size() > 0) else begin
                $display("commit of x%0d at %0t arrived with no instruction outstanding",
                         commit.rd, $time);
                other_fails++;
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                test_commits[want.test]++;
                assert (commit.rd == want.rd && commit.value == want.value) else begin
                    $display("** Error at %0t: test %0d expected x%0d = %h, got x%0d = %h",
                             $time, want.test, want.rd, want.value, commit.rd, commit.value);
                    test_errors[want.test]++;
                end
                assert (commit.tag == want.tag) else begin
                    $display("** Error at %0t: test %0d expected tag %0d, got tag %0d",
                             $time, want.test, want.tag, commit.tag);
                    test_errors[want.test]++;
                end
                if (test_commits[want.test] == test_rows[want.test]) begin
                    $display("test %0d: %0d commits, %0d mismatches, %0d stall cycles",
                             want.test, test_commits[want.test], test_errors[want.test],
                             stall_cycles[want.test]);
                end
            end
        end
    end

    initial begin : main
        bit ok;
        int mismatches;
        load_program();
        build_expected();
        wait_reset(ok);
        if (ok) drive_program(ok);
        if (ok) wait_drain(ok);
        if (ok) begin
            repeat (IDLE_CYCLES) @(negedge clk);   // a repeated retirement would show up here.
        end
        assert (commits == prog.size()) else begin
            $display("%0d commits seen for a program of %0d instructions", commits, prog.size());
            other_fails++;
        end
        assert (stall_cycles[4] > 0) else begin
            $display("instr_ready never dropped during the multiply burst");
            other_fails++;
        end
        mismatches = 0;
        for (int t = 1; t <= NUM_TESTS; t++) mismatches += test_errors[t];
        $display("%0d tests, %0d of %0d commits, %0d mismatches, %0d other failures",
                 NUM_TESTS, commits, prog.size(), mismatches, other_fails);
        if (ok && mismatches == 0 && other_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/ooo_cfg_pkg.sv
logic/ooo_types_pkg.sv
logic/reorder_buffer.sv
logic/arch_regfile.sv
logic/dispatch_unit.sv
logic/reservation_station.sv
logic/exec_pipe.sv
logic/ooo_core_top.sv
dv/clk_rst_gen.sv
dv/ooo_core_tb.sv

//--- Makefile
# Verilator build and run for the out-of-order core testbench.

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed
FAIL_MSG  ?= Regression failed

SOURCES := $(wildcard logic/*.sv dv/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
